/* source/cache_pkg.sv */
package cache_pkg;

   // word address and word geometry
   parameter int ADDR_W     = 12;
   parameter int DATA_W     = 32;
   parameter int NBYTES     = DATA_W / 8;
   parameter int WORD_OFF_W = 2;
   parameter int NWORDS     = 1 << WORD_OFF_W;
   parameter int LINE_W     = NWORDS * DATA_W;

   // front-end request, all-zero strobe is a read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } fe_req_t;

   // backing-memory request
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

   // single-cycle monitor pulses
   typedef struct packed {
      logic rd_hit;
      logic rd_miss;
      logic wr_hit;
      logic wr_miss;
   } cache_event_t;

endpackage

/* source/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram #(
   parameter type ENTRY_T = logic,
   parameter int  DEPTH_W = 4
) (
   input  logic               clk_i,
   input  logic               en_i,
   input  logic               we_i,
   input  logic [DEPTH_W-1:0] addr_i,
   input  ENTRY_T             wdata_i,
   output ENTRY_T             rdata_o
);

   ENTRY_T mem [2**DEPTH_W];

   // whole-row write, read returns the old row
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= wdata_i;
         end
         rdata_o <= mem[addr_i];
      end
   end

endmodule

/* source/cache_replace.sv */
`timescale 1ns/1ps

module cache_replace #(
   parameter int NWAYS    = 2,
   parameter int NLINES_W = 4
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     invalidate_i,
   input  logic [NLINES_W-1:0]      index_i,
   input  logic                     touch_i,
   input  logic [$clog2(NWAYS)-1:0] touch_way_i,
   input  logic                     fill_i,
   input  logic [$clog2(NWAYS)-1:0] fill_way_i,
   output logic [NWAYS-1:0]         valid_o,
   output logic [NWAYS-1:0]         victim_1hot_o
);

   localparam int WAY_W  = $clog2(NWAYS);
   localparam int NLINES = 2**NLINES_W;

   logic [NWAYS-1:0] valid_q [NLINES];
   // heap-ordered tree, node n kept at bit n-1
   logic [NWAYS-2:0] tree_q [NLINES];
   logic [WAY_W-1:0] upd_way;

   // walk from the root and point each node away from the used way
   function automatic logic [NWAYS-2:0] point_away(logic [NWAYS-2:0] tree,
                                                   logic [WAY_W-1:0] way);
      int node;
      node = 1;
      for (int lvl = WAY_W - 1; lvl >= 0; lvl--) begin
         tree[node-1] = ~way[lvl];
         node = 2 * node + int'(way[lvl]);
      end
      return tree;
   endfunction

   // follow the tree bits down to the least recently used leaf
   function automatic logic [WAY_W-1:0] plru_leaf(logic [NWAYS-2:0] tree);
      int node;
      node = 1;
      for (int lvl = 0; lvl < WAY_W; lvl++) begin
         node = 2 * node + int'(tree[node-1]);
      end
      return WAY_W'(node - NWAYS);
   endfunction

   assign upd_way = fill_i ? fill_way_i : touch_way_i;
   assign valid_o = valid_q[index_i];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NLINES; i++) begin
            valid_q[i] <= '0;
            tree_q[i]  <= '0;
         end
      end else begin
         if (invalidate_i) begin
            for (int i = 0; i < NLINES; i++) begin
               valid_q[i] <= '0;
            end
         end else if (fill_i) begin
            valid_q[index_i][fill_way_i] <= 1'b1;
         end
         if (fill_i || touch_i) begin
            tree_q[index_i] <= point_away(tree_q[index_i], upd_way);
         end
      end
   end

   // lowest invalid way wins over the tree
   always_comb begin
      victim_1hot_o = '0;
      victim_1hot_o[plru_leaf(tree_q[index_i])] = 1'b1;
      for (int w = NWAYS - 1; w >= 0; w--) begin
         if (!valid_q[index_i][w]) begin
            victim_1hot_o    = '0;
            victim_1hot_o[w] = 1'b1;
         end
      end
   end

endmodule

/* source/cache_backend.sv */
`timescale 1ns/1ps

module cache_backend (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          start_i,
   input  logic                          fetch_i,
   input  cache_pkg::be_req_t            req_i,
   output logic                          done_o,
   output logic [cache_pkg::LINE_W-1:0]  line_o,
   output cache_pkg::be_req_t            be_req_o,
   output logic                          be_avalid_o,
   input  logic                          be_ready_i,
   input  logic [cache_pkg::DATA_W-1:0]  be_rdata_i,
   input  logic                          be_rvalid_i
);

   localparam int OFF_W  = cache_pkg::WORD_OFF_W;
   localparam int DATA_W = cache_pkg::DATA_W;

   logic               busy_q;
   logic               fetch_q;
   cache_pkg::be_req_t cmd_q;
   logic [OFF_W:0]     issued_q;
   logic [OFF_W-1:0]   returned_q;
   logic               all_issued;
   logic               accept;
   logic               take_word;
   logic               last_word;

   // a fetch walks the whole line, a write is one request
   assign all_issued = fetch_q ? (issued_q == (OFF_W+1)'(cache_pkg::NWORDS))
                               : (issued_q != '0);
   assign be_avalid_o = busy_q & ~all_issued;
   assign accept      = be_avalid_o & be_ready_i;
   assign take_word   = busy_q & fetch_q & be_rvalid_i;
   assign last_word   = take_word & (returned_q == OFF_W'(cache_pkg::NWORDS - 1));

   // word offset comes from the issue counter during a fetch
   always_comb begin
      be_req_o = cmd_q;
      if (fetch_q) begin
         be_req_o.addr[OFF_W-1:0] = issued_q[OFF_W-1:0];
         be_req_o.wstrb           = '0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q     <= 1'b0;
         fetch_q    <= 1'b0;
         issued_q   <= '0;
         returned_q <= '0;
         done_o     <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy_q     <= 1'b1;
            fetch_q    <= fetch_i;
            issued_q   <= '0;
            returned_q <= '0;
         end else if (busy_q) begin
            if (accept) begin
               issued_q <= issued_q + 1'b1;
            end
            if (take_word) begin
               returned_q <= returned_q + 1'b1;
            end
            // last word back, or the write was taken
            if (last_word || (accept && !fetch_q)) begin
               busy_q <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         cmd_q <= req_i;
      end
      if (take_word) begin
         line_o[returned_q*DATA_W +: DATA_W] <= be_rdata_i;
      end
   end

endmodule

/* source/cache_core.sv */
`timescale 1ns/1ps

module cache_core #(
   parameter int NWAYS    = 2,
   parameter int NLINES_W = 4,
   parameter int TAG_W    = 6
) (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  cache_pkg::fe_req_t                  fe_req_i,
   input  logic                                fe_avalid_i,
   output logic                                fe_ready_o,
   output logic [cache_pkg::DATA_W-1:0]        fe_rdata_o,
   output logic                                fe_rvalid_o,
   output cache_pkg::cache_event_t             event_o,
   // tag RAM
   output logic                                tag_en_o,
   output logic                                tag_we_o,
   output logic [NLINES_W-1:0]                 tag_addr_o,
   output logic [NWAYS-1:0][TAG_W-1:0]         tag_wdata_o,
   input  logic [NWAYS-1:0][TAG_W-1:0]         tag_rdata_i,
   // data RAM
   output logic                                data_en_o,
   output logic                                data_we_o,
   output logic [NLINES_W-1:0]                 data_addr_o,
   output logic [NWAYS-1:0][cache_pkg::NWORDS-1:0][cache_pkg::DATA_W-1:0] data_wdata_o,
   input  logic [NWAYS-1:0][cache_pkg::NWORDS-1:0][cache_pkg::DATA_W-1:0] data_rdata_i,
   // replace unit
   output logic [NLINES_W-1:0]                 rep_index_o,
   output logic                                rep_touch_o,
   output logic [$clog2(NWAYS)-1:0]            rep_touch_way_o,
   output logic                                rep_fill_o,
   output logic [$clog2(NWAYS)-1:0]            rep_fill_way_o,
   input  logic [NWAYS-1:0]                    rep_valid_i,
   input  logic [NWAYS-1:0]                    rep_victim_1hot_i,
   // backend
   output logic                                be_start_o,
   output logic                                be_fetch_o,
   output cache_pkg::be_req_t                  be_cmd_o,
   input  logic                                be_done_i,
   input  logic [cache_pkg::LINE_W-1:0]        be_line_i
);

   localparam int WAY_W  = $clog2(NWAYS);
   localparam int OFF_W  = cache_pkg::WORD_OFF_W;
   localparam int DATA_W = cache_pkg::DATA_W;

   typedef enum logic [1:0] {S_IDLE, S_REFILL, S_WRITE} state_e;

   state_e             state_q;
   cache_pkg::fe_req_t req_q;
   logic               lookup_q;
   logic               rsp_q;
   logic [DATA_W-1:0]  rsp_word_q;

   logic [TAG_W-1:0]    tag_r;
   logic [NLINES_W-1:0] index_r;
   logic [NLINES_W-1:0] fe_index;
   logic [OFF_W-1:0]    off_r;
   logic                is_wr;
   logic                hit;
   logic                accept;
   logic                fill;
   logic [NWAYS-1:0]    hit_1hot;
   logic [WAY_W-1:0]    hit_way;
   logic [WAY_W-1:0]    victim_way;

   // address split of the registered request
   assign tag_r    = req_q.addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign index_r  = req_q.addr[OFF_W +: NLINES_W];
   assign off_r    = req_q.addr[OFF_W-1:0];
   assign fe_index = fe_req_i.addr[OFF_W +: NLINES_W];
   assign is_wr    = |req_q.wstrb;

   // tag compare on valid ways, one-hot to binary
   always_comb begin
      hit_way    = '0;
      victim_way = '0;
      for (int w = 0; w < NWAYS; w++) begin
         hit_1hot[w] = rep_valid_i[w] & (tag_rdata_i[w] == tag_r);
         if (hit_1hot[w]) hit_way = WAY_W'(w);
         if (rep_victim_1hot_i[w]) victim_way = WAY_W'(w);
      end
   end
   assign hit = |hit_1hot;

   assign event_o.rd_hit  = lookup_q & ~is_wr & hit;
   assign event_o.rd_miss = lookup_q & ~is_wr & ~hit;
   assign event_o.wr_hit  = lookup_q & is_wr & hit;
   assign event_o.wr_miss = lookup_q & is_wr & ~hit;

   // only read hits keep the front end open
   assign fe_ready_o = (state_q == S_IDLE) & ~(lookup_q & (is_wr | ~hit));
   assign accept     = fe_avalid_i & fe_ready_o;
   assign fill       = (state_q == S_REFILL) & be_done_i;

   assign tag_en_o    = accept | fill;
   assign tag_we_o    = fill;
   assign tag_addr_o  = fill ? index_r : fe_index;
   assign data_en_o   = accept | fill | event_o.wr_hit;
   assign data_we_o   = fill | event_o.wr_hit;
   assign data_addr_o = data_we_o ? index_r : fe_index;

   // refill replaces the victim way, a write hit merges strobed bytes
   always_comb begin
      tag_wdata_o             = tag_rdata_i;
      tag_wdata_o[victim_way] = tag_r;
      data_wdata_o            = data_rdata_i;
      if (fill) begin
         data_wdata_o[victim_way] = be_line_i;
      end else begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (req_q.wstrb[b]) begin
               data_wdata_o[hit_way][off_r][8*b +: 8] = req_q.wdata[8*b +: 8];
            end
         end
      end
   end

   assign rep_index_o     = index_r;
   assign rep_touch_o     = lookup_q & hit;
   assign rep_touch_way_o = hit_way;
   assign rep_fill_o      = fill;
   assign rep_fill_way_o  = victim_way;

   // every write goes through, read misses fetch the line
   assign be_start_o = lookup_q & (is_wr | ~hit);
   assign be_fetch_o = ~is_wr;
   assign be_cmd_o   = cache_pkg::be_req_t'(req_q);

   assign fe_rvalid_o = event_o.rd_hit | rsp_q;
   assign fe_rdata_o  = rsp_q ? rsp_word_q : data_rdata_i[hit_way][off_r];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= S_IDLE;
         lookup_q <= 1'b0;
         rsp_q    <= 1'b0;
      end else begin
         lookup_q <= accept;
         rsp_q    <= fill;
         case (state_q)
            S_IDLE: begin
               if (be_start_o) begin
                  state_q <= is_wr ? S_WRITE : S_REFILL;
               end
            end
            S_REFILL, S_WRITE: begin
               if (be_done_i) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      // requested word of the refilled line
      if (fill) begin
         rsp_word_q <= be_line_i[off_r*DATA_W +: DATA_W];
      end
   end

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
   parameter int NWAYS    = 2,
   parameter int NLINES_W = 4
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  cache_pkg::fe_req_t            fe_req_i,
   input  logic                          fe_avalid_i,
   output logic                          fe_ready_o,
   output logic [cache_pkg::DATA_W-1:0]  fe_rdata_o,
   output logic                          fe_rvalid_o,
   input  logic                          invalidate_i,
   output cache_pkg::cache_event_t       event_o,
   output cache_pkg::be_req_t            be_req_o,
   output logic                          be_avalid_o,
   input  logic                          be_ready_i,
   input  logic [cache_pkg::DATA_W-1:0]  be_rdata_i,
   input  logic                          be_rvalid_i
);

   localparam int TAG_W = cache_pkg::ADDR_W - NLINES_W - cache_pkg::WORD_OFF_W;
   localparam int WAY_W = $clog2(NWAYS);

   // one RAM row holds all ways of a line index
   typedef logic [NWAYS-1:0][TAG_W-1:0] tag_row_t;
   typedef logic [NWAYS-1:0][cache_pkg::NWORDS-1:0][cache_pkg::DATA_W-1:0] data_row_t;

   logic                         tag_en;
   logic                         tag_we;
   logic [NLINES_W-1:0]          tag_addr;
   tag_row_t                     tag_wdata;
   tag_row_t                     tag_rdata;
   logic                         data_en;
   logic                         data_we;
   logic [NLINES_W-1:0]          data_addr;
   data_row_t                    data_wdata;
   data_row_t                    data_rdata;
   logic [NLINES_W-1:0]          rep_index;
   logic                         rep_touch;
   logic [WAY_W-1:0]             rep_touch_way;
   logic                         rep_fill;
   logic [WAY_W-1:0]             rep_fill_way;
   logic [NWAYS-1:0]             rep_valid;
   logic [NWAYS-1:0]             rep_victim_1hot;
   logic                         be_start;
   logic                         be_fetch;
   cache_pkg::be_req_t           be_cmd;
   logic                         be_done;
   logic [cache_pkg::LINE_W-1:0] be_line;

   cache_core #(
      .NWAYS    (NWAYS),
      .NLINES_W (NLINES_W),
      .TAG_W    (TAG_W)
   ) u_core (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .fe_req_i          (fe_req_i),
      .fe_avalid_i       (fe_avalid_i),
      .fe_ready_o        (fe_ready_o),
      .fe_rdata_o        (fe_rdata_o),
      .fe_rvalid_o       (fe_rvalid_o),
      .event_o           (event_o),
      .tag_en_o          (tag_en),
      .tag_we_o          (tag_we),
      .tag_addr_o        (tag_addr),
      .tag_wdata_o       (tag_wdata),
      .tag_rdata_i       (tag_rdata),
      .data_en_o         (data_en),
      .data_we_o         (data_we),
      .data_addr_o       (data_addr),
      .data_wdata_o      (data_wdata),
      .data_rdata_i      (data_rdata),
      .rep_index_o       (rep_index),
      .rep_touch_o       (rep_touch),
      .rep_touch_way_o   (rep_touch_way),
      .rep_fill_o        (rep_fill),
      .rep_fill_way_o    (rep_fill_way),
      .rep_valid_i       (rep_valid),
      .rep_victim_1hot_i (rep_victim_1hot),
      .be_start_o        (be_start),
      .be_fetch_o        (be_fetch),
      .be_cmd_o          (be_cmd),
      .be_done_i         (be_done),
      .be_line_i         (be_line)
   );

   cache_ram #(
      .ENTRY_T (tag_row_t),
      .DEPTH_W (NLINES_W)
   ) u_tag_ram (
      .clk_i   (clk_i),
      .en_i    (tag_en),
      .we_i    (tag_we),
      .addr_i  (tag_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   cache_ram #(
      .ENTRY_T (data_row_t),
      .DEPTH_W (NLINES_W)
   ) u_data_ram (
      .clk_i   (clk_i),
      .en_i    (data_en),
      .we_i    (data_we),
      .addr_i  (data_addr),
      .wdata_i (data_wdata),
      .rdata_o (data_rdata)
   );

   cache_replace #(
      .NWAYS    (NWAYS),
      .NLINES_W (NLINES_W)
   ) u_replace (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .invalidate_i  (invalidate_i),
      .index_i       (rep_index),
      .touch_i       (rep_touch),
      .touch_way_i   (rep_touch_way),
      .fill_i        (rep_fill),
      .fill_way_i    (rep_fill_way),
      .valid_o       (rep_valid),
      .victim_1hot_o (rep_victim_1hot)
   );

   cache_backend u_backend (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (be_start),
      .fetch_i     (be_fetch),
      .req_i       (be_cmd),
      .done_o      (be_done),
      .line_o      (be_line),
      .be_req_o    (be_req_o),
      .be_avalid_o (be_avalid_o),
      .be_ready_i  (be_ready_i),
      .be_rdata_i  (be_rdata_i),
      .be_rvalid_i (be_rvalid_i)
   );

endmodule

/* dv/backing_mem.sv */
`timescale 1ns/1ps

module backing_mem (
   input  logic                         clk_i,
   input  cache_pkg::be_req_t           req_i,
   input  logic                         avalid_i,
   output logic                         ready_o,
   output logic [cache_pkg::DATA_W-1:0] rdata_o,
   output logic                         rvalid_o
);

   localparam int DEPTH = 4096;

   logic [cache_pkg::DATA_W-1:0] mem [DEPTH];
   // read words in flight and the cycle each one is due
   logic [cache_pkg::DATA_W-1:0] data_q [$];
   int unsigned                  due_q [$];
   int unsigned                  cycle;
   int unsigned                  last_due;

   initial begin
      ready_o  = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      cycle    = 0;
      last_due = 0;
   end

   task automatic preload();
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = $urandom();
      end
   endtask

   always @(posedge clk_i) begin
      int unsigned due;
      cycle = cycle + 1;
      if (avalid_i && ready_o) begin
         if (req_i.wstrb == '0) begin
            // latency 1 to 6, answers stay in request order
            due = cycle + $urandom_range(1, 6) - 1;
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            data_q.push_back(mem[req_i.addr]);
            due_q.push_back(due);
         end else begin
            for (int b = 0; b < cache_pkg::NBYTES; b++) begin
               if (req_i.wstrb[b]) begin
                  mem[req_i.addr][8*b +: 8] = req_i.wdata[8*b +: 8];
               end
            end
         end
      end
      #1;
      ready_o = ($urandom_range(0, 3) != 0);
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
         rvalid_o = 1'b1;
         rdata_o  = data_q.pop_front();
         void'(due_q.pop_front());
      end else begin
         rvalid_o = 1'b0;
      end
   end

endmodule

/* dv/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

   localparam int NWAYS    = 2;
   localparam int NLINES_W = 4;
   localparam int NLINES   = 1 << NLINES_W;
   localparam int TAG_W    = cache_pkg::ADDR_W - NLINES_W - cache_pkg::WORD_OFF_W;
   localparam int MEM_WORDS = 4096;
   localparam int TIMEOUT  = 200;
   localparam logic [31:0] SEED = 32'hda97f561;
   // event bits in struct order: rd_hit, rd_miss, wr_hit, wr_miss
   localparam logic [3:0] RD_HIT  = 4'b1000;
   localparam logic [3:0] RD_MISS = 4'b0100;
   localparam logic [3:0] WR_HIT  = 4'b0010;
   localparam logic [3:0] WR_MISS = 4'b0001;

   logic                         clk;
   logic                         rst_n;
   cache_pkg::fe_req_t           fe_req;
   logic                         fe_avalid;
   logic                         fe_ready;
   logic [cache_pkg::DATA_W-1:0] fe_rdata;
   logic                         fe_rvalid;
   logic                         invalidate;
   cache_pkg::cache_event_t      evt;
   cache_pkg::be_req_t           be_req;
   logic                         be_avalid;
   logic                         be_ready;
   logic [cache_pkg::DATA_W-1:0] be_rdata;
   logic                         be_rvalid;

   // shadow model of memory and of the cache directory
   logic [31:0]      shadow [MEM_WORDS];
   logic [TAG_W-1:0] tag_m [NLINES][NWAYS];
   logic             valid_m [NLINES][NWAYS];
   // way to evict once both ways are valid
   logic             lru_m [NLINES];

   cache_top #(
      .NWAYS    (NWAYS),
      .NLINES_W (NLINES_W)
   ) dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .fe_req_i     (fe_req),
      .fe_avalid_i  (fe_avalid),
      .fe_ready_o   (fe_ready),
      .fe_rdata_o   (fe_rdata),
      .fe_rvalid_o  (fe_rvalid),
      .invalidate_i (invalidate),
      .event_o      (evt),
      .be_req_o     (be_req),
      .be_avalid_o  (be_avalid),
      .be_ready_i   (be_ready),
      .be_rdata_i   (be_rdata),
      .be_rvalid_i  (be_rvalid)
   );

   backing_mem mem_i (
      .clk_i    (clk),
      .req_i    (be_req),
      .avalid_i (be_avalid),
      .ready_o  (be_ready),
      .rdata_o  (be_rdata),
      .rvalid_o (be_rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
         $display("test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t while waiting for %s", $time, what);
      $display("test failed");
      $fatal(1, "stopped on timeout");
   endtask

   // predicts the event and updates the shadow state for one request
   task automatic model_access(input logic [11:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, output logic [3:0] exp_ev);
      int               idx;
      int               way;
      logic             hit;
      logic [TAG_W-1:0] tag;
      idx = int'(addr[cache_pkg::WORD_OFF_W +: NLINES_W]);
      tag = addr[cache_pkg::ADDR_W-1 -: TAG_W];
      hit = 1'b0;
      way = 0;
      for (int w = 0; w < NWAYS; w++) begin
         if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
            hit = 1'b1;
            way = w;
         end
      end
      if (wstrb == '0) begin
         exp_ev = hit ? RD_HIT : RD_MISS;
         if (!hit) begin
            // lowest invalid way first
            if (!valid_m[idx][0]) begin
               way = 0;
            end else if (!valid_m[idx][1]) begin
               way = 1;
            end else begin
               way = int'(lru_m[idx]);
            end
            tag_m[idx][way]   = tag;
            valid_m[idx][way] = 1'b1;
         end
         lru_m[idx] = (way == 0);
      end else begin
         exp_ev = hit ? WR_HIT : WR_MISS;
         if (hit) begin
            lru_m[idx] = (way == 0);
         end
         for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
               shadow[addr][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
   endtask

   // one request from drive to completion, starts and ends 1 ns after an edge
   task automatic access(input logic [11:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, output logic [31:0] rdata,
                         output logic [3:0] ev);
      int         n;
      logic [3:0] exp_ev;
      model_access(addr, wdata, wstrb, exp_ev);
      fe_req.addr  = addr;
      fe_req.wdata = wdata;
      fe_req.wstrb = wstrb;
      fe_avalid    = 1'b1;
      n = 0;
      @(negedge clk);
      while (!fe_ready) begin
         n++;
         if (n > TIMEOUT) report_timeout("fe_ready_o before accept");
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      fe_avalid = 1'b0;
      @(negedge clk);
      ev = evt;
      check_eq(32'(ev), 32'(exp_ev), "event in lookup cycle");
      n = 1;
      if (wstrb == '0) begin
         while (!fe_rvalid) begin
            n++;
            if (n > TIMEOUT) report_timeout("fe_rvalid_o");
            @(negedge clk);
         end
         rdata = fe_rdata;
         check_eq(rdata, shadow[addr], "read data");
         if (exp_ev == RD_HIT) begin
            check_eq(32'(n), 32'd1, "read hit latency");
         end
      end else begin
         rdata = '0;
         while (!fe_ready) begin
            n++;
            if (n > TIMEOUT) report_timeout("fe_ready_o after write");
            @(negedge clk);
         end
         check_eq(mem_i.mem[addr], shadow[addr], "backing memory word");
      end
      @(posedge clk);
      #1;
   endtask

   task automatic read_miss_then_hit();
      logic [31:0] rd;
      logic [3:0]  ev;
      access(12'h040, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "first read misses");
      access(12'h043, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_HIT), "same line hits");
   endtask

   task automatic streaming_hits();
      logic [11:0] addrs [8];
      logic [31:0] rd;
      logic [3:0]  ev;
      logic [3:0]  exp_ev;
      access(12'h100, 32'h0, 4'h0, rd, ev);
      access(12'h104, 32'h0, 4'h0, rd, ev);
      for (int i = 0; i < 8; i++) begin
         addrs[i] = 12'h100 + 12'((i % 2) * 4 + i / 2);
      end
      // one read in lookup while the next is accepted
      for (int i = 0; i <= 8; i++) begin
         if (i < 8) begin
            fe_req.addr  = addrs[i];
            fe_req.wdata = '0;
            fe_req.wstrb = '0;
            fe_avalid    = 1'b1;
         end else begin
            fe_avalid = 1'b0;
         end
         @(negedge clk);
         if (i < 8) begin
            check_eq(32'(fe_ready), 32'd1, "fe_ready_o high while streaming");
         end
         if (i > 0) begin
            model_access(addrs[i-1], 32'h0, 4'h0, exp_ev);
            check_eq(32'(evt), 32'(exp_ev), "streamed event");
            check_eq(32'(fe_rvalid), 32'd1, "streamed rvalid");
            check_eq(fe_rdata, shadow[addrs[i-1]], "streamed data");
         end else begin
            check_eq(32'(fe_rvalid), 32'd0, "no rvalid before first lookup");
         end
         @(posedge clk);
         #1;
      end
      // exactly one rvalid per streamed read
      @(negedge clk);
      check_eq(32'(fe_rvalid), 32'd0, "no rvalid after last streamed read");
      @(posedge clk);
      #1;
   endtask

   task automatic write_strobes();
      logic [31:0] rd;
      logic [31:0] old;
      logic [31:0] merged;
      logic [3:0]  ev;
      old    = shadow[12'h041];
      merged = {old[31:24], 8'h5a, old[15:8], 8'h3c};
      access(12'h041, 32'hc35a_963c, 4'b0101, rd, ev);
      check_eq(32'(ev), 32'(WR_HIT), "write hit event");
      access(12'h041, 32'h0, 4'h0, rd, ev);
      check_eq(rd, merged, "merged word after partial write");
      check_eq(mem_i.mem[12'h041], merged, "backing memory merged word");
      access(12'h3c8, 32'h1234_5678, 4'b1111, rd, ev);
      check_eq(32'(ev), 32'(WR_MISS), "write miss event");
      access(12'h3c8, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "write miss did not allocate");
   endtask

   task automatic replacement();
      logic [31:0] rd;
      logic [3:0]  ev;
      // tags 1, 2 and 3 at index 5
      access(12'h054, 32'h0, 4'h0, rd, ev);
      access(12'h094, 32'h0, 4'h0, rd, ev);
      access(12'h054, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_HIT), "first tag touched again");
      access(12'h0d4, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "third tag misses");
      access(12'h055, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_HIT), "recently used tag kept");
      access(12'h096, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "least recently used tag evicted");
   endtask

   task automatic invalidate_all();
      logic [31:0] rd;
      logic [3:0]  ev;
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
      for (int i = 0; i < NLINES; i++) begin
         for (int w = 0; w < NWAYS; w++) begin
            valid_m[i][w] = 1'b0;
         end
      end
      access(12'h041, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "line gone after invalidate");
      access(12'h102, 32'h0, 4'h0, rd, ev);
      check_eq(32'(ev), 32'(RD_MISS), "second line gone after invalidate");
   endtask

   task automatic random_mix();
      logic [11:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic [31:0] rd;
      logic [3:0]  ev;
      // three tags on two indexes keep evictions frequent
      for (int i = 0; i < 300; i++) begin
         addr  = {6'($urandom_range(0, 2)), 4'($urandom_range(6, 7)),
                  2'($urandom_range(0, 3))};
         wdata = $urandom();
         wstrb = ($urandom_range(0, 2) == 0) ? 4'($urandom_range(1, 15)) : 4'h0;
         access(addr, wdata, wstrb, rd, ev);
      end
   endtask

   initial begin
      fe_req     = '0;
      fe_avalid  = 1'b0;
      invalidate = 1'b0;
      rst_n      = 1'b0;
      void'($urandom(SEED));
      mem_i.preload();
      for (int i = 0; i < MEM_WORDS; i++) begin
         shadow[i] = mem_i.mem[i];
      end
      for (int i = 0; i < NLINES; i++) begin
         lru_m[i] = 1'b0;
         for (int w = 0; w < NWAYS; w++) begin
            valid_m[i][w] = 1'b0;
            tag_m[i][w]   = '0;
         end
      end
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_eq(32'(fe_ready), 32'd1, "fe_ready_o after reset");
      check_eq(32'(fe_rvalid), 32'd0, "fe_rvalid_o after reset");
      check_eq(32'(be_avalid), 32'd0, "be_avalid_o after reset");
      check_eq(32'(evt), 32'd0, "events after reset");
      @(posedge clk);
      #1;
      read_miss_then_hit();
      streaming_hits();
      write_strobes();
      replacement();
      invalidate_all();
      random_mix();
      $display("test passed");
      $finish;
   end

endmodule

/* filelist.f */
source/cache_pkg.sv
source/cache_ram.sv
source/cache_replace.sv
source/cache_backend.sv
source/cache_core.sv
source/cache_top.sv
dv/backing_mem.sv
dv/cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cache_tb -Mdir obj_dir -f filelist.f

# the simulation may stop early, the search below decides the result
out=$(./obj_dir/Vcache_tb 2>&1) || true
echo "$out"

echo "$out" | grep -qx "test passed"
